//--- files.f
+incdir+tb
verilog/isf_dbg_pkg.sv
verilog/watermark_flow.sv
verilog/tlv_trigger.sv
verilog/debug_gate.sv
verilog/isf_ib_debug_ctrl.sv
tb/tb_isf_ib_debug_ctrl.sv

//--- tb/tb_ref_model.svh
// Reference model for the inbound debug controller testbench, included in
// the testbench module body. Holds the xorshift generator and the functions
// that give the expected back-pressure, FIFO strobes and trigger match.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [63:0] rng_state;                          // Never zero once seeded

function automatic logic [63:0] rand64();
  logic [63:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 7);
  x = x ^ (x << 17);
  rng_state = x;
  return x;
endfunction

// Entries that a watermark select code stands for
function automatic int wmark_size(input int sel);
  return (sel + 1) * 8;
endfunction

function automatic int high_level(input int entries, input int use_sel);
  return entries - wmark_size(use_sel);
endfunction

function automatic int low_level(input int entries, input int use_sel, input int req_sel);
  return entries - wmark_size(use_sel) - wmark_size(req_sel);
endfunction

// Back-pressure state after the next rising edge
function automatic logic next_full(input logic full, input int depth, input int entries,
                                   input int use_sel, input int req_sel);
  return full ? (depth > low_level(entries, use_sel, req_sel))
              : (depth >= high_level(entries, use_sel));
endfunction

function automatic logic expect_wr(input int mode, input logic slv_empty, input logic full,
                                   input logic force_bp);
  logic wr;
  wr = !slv_empty && !full;
  case (mode)
    0:       return wr && !force_bp;
    1:       return 1'b0;
    default: return wr;                          // Force only counts in normal mode
  endcase
endfunction

function automatic logic expect_rd(input int mode, input int depth, input logic afull);
  return (mode != 1) && (mode != 2) && (depth != 0) && !afull;
endfunction

function automatic logic masked_match(input logic [63:0] word, input logic [63:0] match_val,
                                      input logic [63:0] mask_val);
  return ((word ^ match_val) & mask_val) == 64'd0;
endfunction

`endif

//--- tb/tb_isf_ib_debug_ctrl.sv
// Testbench for the inbound debug and flow controller. It runs the watermark
// hysteresis, the debug-mode gating of the FIFO strobes and the TLV trigger
// at word 0 and word 3. Inputs change 2 time units after the rising edge and
// a compare process checks every output on the falling edge.
module tb_isf_ib_debug_ctrl;

  import isf_dbg_pkg::*;

  localparam int fifo_entries = 256;
  localparam int depth_w      = $clog2(fifo_entries + 1);
  localparam int ramp_lo      = 64;
  localparam int test_cycles  = 10 + 4 * (fifo_entries - ramp_lo + 1) + 2 * 5 * 16 + 50;
  localparam int max_cycles   = 2 * test_cycles;

  logic               clk, rst_n;
  debug_mode_e        debug_mode;
  logic               force_ib_bp;
  wmark_sel_t         use_wmark_sel, req_wmark_sel;
  tlv_type_t          trig_tlv_type;
  word_num_t          trig_word_num;
  tlv_data_t          trig_match_val, trig_mask_val;
  logic [depth_w-1:0] fifo_depth;
  logic               axi_slv_empty, axi_slv_rd;
  logic               pre_tlvp_fifo_afull, pre_tlvp_fifo_empty, pre_tlvp_fifo_rd;
  tlv_data_t          tlv_data;
  logic               tlv_sop;
  logic               isf_fifo_hw_wr, isf_fifo_hw_rd;
  logic               pre_tlvp_fifo_empty_mod, pre_tlvp_fifo_wr;
  logic               trigger_hit;
  tlv_data_t          trig_cap;

  logic               exp_full, exp_pwr, exp_wr, exp_rd;
  logic               exp_freeze, exp_hit;
  tlv_data_t          exp_cap;
  tlv_data_t          tlv_words [0:3];
  string              test_name;
  int                 checks, errors, test_errors, tests, cycles;

  `include "tb_ref_model.svh"

  isf_ib_debug_ctrl #(.fifo_entries(fifo_entries)) DUT (.*);

  always #20 clk = ~clk;

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string sig, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    checks++;
    assert (act_val === exp_val)
    else
    begin
      errors++;
      test_errors++;
      $display("Fail %s %s: expected %0h, actual %0h", test_name, sig, exp_val, act_val);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tick();                                      // Let the last cycle be checked first
    tests++;
    $display("%-14s %0d errors", test_name, test_errors);
  endtask

  // Compare process; registered outputs are predicted one edge ahead
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      exp_full = 1'b0;
      exp_pwr  = 1'b0;
    end
    else
    begin
      exp_wr = expect_wr(int'(debug_mode), axi_slv_empty, exp_full, force_ib_bp);
      exp_rd = expect_rd(int'(debug_mode), int'(fifo_depth), pre_tlvp_fifo_afull);
      check_value("isf_fifo_hw_wr", exp_wr, isf_fifo_hw_wr);
      check_value("axi_slv_rd", exp_wr, axi_slv_rd);
      check_value("isf_fifo_hw_rd", exp_rd, isf_fifo_hw_rd);
      check_value("pre_tlvp_fifo_wr", exp_pwr, pre_tlvp_fifo_wr);
      check_value("pre_tlvp_fifo_empty_mod", pre_tlvp_fifo_empty || exp_freeze,
                  pre_tlvp_fifo_empty_mod);
      check_value("trigger_hit", exp_hit, trigger_hit);
      check_value("trig_cap", exp_cap, trig_cap);
      exp_pwr  = exp_rd && !pre_tlvp_fifo_afull;
      exp_full = next_full(exp_full, int'(fifo_depth), fifo_entries, int'(use_wmark_sel),
                           int'(req_wmark_sel));
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("test failed");
      $finish;
    end
  end

  // Reads n words of tlv_words; the word at index target is the trigger word
  task automatic read_tlv(input int n, input int target, input logic is_match);
    int i;
    for (i = 0; i <= n + 1; i++)
    begin
      tick();
      pre_tlvp_fifo_rd = i < n;
      tlv_sop          = i == 1;                 // Read data lags the strobe by one cycle
      tlv_data         = (i >= 1 && i <= n) ? tlv_words[i-1] : '0;
      if (i == target + 1)
      begin
        exp_freeze = is_match;
      end
      if (i == target + 2)
      begin
        exp_hit = is_match;
        if (is_match)
        begin
          exp_cap = tlv_words[target];           // Capture register loads with the hit
        end
      end
    end
  endtask

  task automatic leave_freeze();
    tick();
    debug_mode = DBG_NORMAL;
    exp_freeze = 1'b0;
    tick();
    exp_hit = 1'b0;
  endtask

  task automatic new_trigger(input int word_num);
    tick();
    trig_word_num  = word_num_t'(word_num);
    trig_tlv_type  = tlv_type_t'(rand64());
    trig_mask_val  = rand64() | 64'h100;         // Bit 8 always compared
    trig_match_val = rand64();
    trig_match_val[TLV_TYPE_W-1:0] = trig_tlv_type;
  endtask

  initial
  begin
    clk = 1'b0;
    rst_n = 1'b0;
    debug_mode = DBG_NORMAL;
    force_ib_bp = 1'b0;
    use_wmark_sel = '0;
    req_wmark_sel = '0;
    trig_tlv_type = '0;
    trig_word_num = '0;
    trig_match_val = '0;
    trig_mask_val = '0;
    fifo_depth = '0;
    axi_slv_empty = 1'b0;
    pre_tlvp_fifo_afull = 1'b0;
    pre_tlvp_fifo_empty = 1'b0;
    pre_tlvp_fifo_rd = 1'b0;
    tlv_data = '0;
    tlv_sop = 1'b0;
    exp_freeze = 1'b0;
    exp_hit = 1'b0;
    exp_cap = '0;
    rng_state = 64'd10926;
    checks = 0;
    errors = 0;
    tests = 0;
    cycles = 0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    start_test("hysteresis");
    for (int r = 0; r < 2; r++)
    begin
      tick();
      use_wmark_sel = wmark_sel_t'(rand64());
      req_wmark_sel = wmark_sel_t'(rand64());
      for (int d = ramp_lo; d <= fifo_entries; d++)
      begin
        tick();
        fifo_depth = depth_w'(d);
      end
      for (int d = fifo_entries; d >= ramp_lo; d--)
      begin
        tick();
        fifo_depth = depth_w'(d);
      end
    end
    finish_test();

    // Pass 0 keeps the depth at or below the low level, pass 1 above it
    start_test("mode_gating");
    for (int p = 0; p < 2; p++)
    begin
      if (p == 1)
      begin
        tick();
        fifo_depth = depth_w'(fifo_entries);
      end
      for (int m = 0; m < 5; m++)
      begin
        for (int k = 0; k < 16; k++)
        begin
          logic [63:0] rnd;
          int          low;
          low = low_level(fifo_entries, int'(use_wmark_sel), int'(req_wmark_sel));
          rnd = rand64();
          tick();
          debug_mode          = debug_mode_e'(m);
          axi_slv_empty       = rnd[0];
          pre_tlvp_fifo_afull = rnd[1];
          pre_tlvp_fifo_empty = rnd[2];
          force_ib_bp         = rnd[3];
          fifo_depth = (p == 0) ? depth_w'(int'(rnd[31:16]) % (low + 1))
                                : depth_w'(low + 1 + int'(rnd[31:16]) % (fifo_entries - low));
        end
      end
    end
    tick();
    debug_mode = DBG_NORMAL;
    {axi_slv_empty, pre_tlvp_fifo_afull, pre_tlvp_fifo_empty, force_ib_bp} = '0;
    fifo_depth = depth_w'(16);
    finish_test();

    start_test("trigger_word0");
    new_trigger(0);
    tlv_words[0] = (trig_match_val & trig_mask_val) | (rand64() & ~trig_mask_val);
    tlv_words[0][TLV_TYPE_W-1:0] = trig_tlv_type;  // Type field selects this TLV
    tick();
    debug_mode = DBG_TRIG_FREEZE;
    read_tlv(1, 0, masked_match(tlv_words[0], trig_match_val, trig_mask_val));
    tick();
    leave_freeze();
    finish_test();

    start_test("trigger_word3");
    new_trigger(3);
    tlv_words[0] = rand64();
    tlv_words[0][TLV_TYPE_W-1:0] = trig_tlv_type;
    tlv_words[1] = rand64();
    tlv_words[2] = rand64();
    tlv_words[3] = (trig_match_val & trig_mask_val) | (rand64() & ~trig_mask_val);
    tlv_words[3] = tlv_words[3] ^ 64'h100;       // Differs in a masked bit
    tick();
    debug_mode = DBG_TRIG_FREEZE;
    read_tlv(4, 3, masked_match(tlv_words[3], trig_match_val, trig_mask_val));
    tlv_words[3] = tlv_words[3] ^ 64'h100;
    read_tlv(4, 3, masked_match(tlv_words[3], trig_match_val, trig_mask_val));
    tick();
    leave_freeze();
    finish_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verilog/isf_ib_debug_ctrl.sv
// Top level of the inbound debug and flow controller. The watermark state
// machine and the TLV trigger run side by side; the debug gate merges their
// results into the FIFO strobes. Configuration inputs are static registers.
// fifo_entries sets the inbound FIFO size and must be above 128.
module isf_ib_debug_ctrl #(
  parameter int fifo_entries = 256,
  localparam int depth_w = $clog2(fifo_entries + 1)
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  isf_dbg_pkg::debug_mode_e debug_mode,
  input  logic                     force_ib_bp,
  input  isf_dbg_pkg::wmark_sel_t  use_wmark_sel,
  input  isf_dbg_pkg::wmark_sel_t  req_wmark_sel,
  input  isf_dbg_pkg::tlv_type_t   trig_tlv_type,
  input  isf_dbg_pkg::word_num_t   trig_word_num,
  input  isf_dbg_pkg::tlv_data_t   trig_match_val,
  input  isf_dbg_pkg::tlv_data_t   trig_mask_val,
  input  logic [depth_w-1:0]       fifo_depth,
  input  logic                     axi_slv_empty,
  output logic                     axi_slv_rd,
  input  logic                     pre_tlvp_fifo_afull,
  input  logic                     pre_tlvp_fifo_empty,
  input  logic                     pre_tlvp_fifo_rd,
  input  isf_dbg_pkg::tlv_data_t   tlv_data,
  input  logic                     tlv_sop,
  output logic                     isf_fifo_hw_wr,
  output logic                     isf_fifo_hw_rd,
  output logic                     pre_tlvp_fifo_empty_mod,
  output logic                     pre_tlvp_fifo_wr,
  output logic                     trigger_hit,
  output isf_dbg_pkg::tlv_data_t   trig_cap
);

  logic fifo_full;
  logic freeze_hold;
  logic tlv_rd_d;

  watermark_flow #(.fifo_entries(fifo_entries)) u_watermark_flow (
    .clk           (clk),
    .rst_n         (rst_n),
    .use_wmark_sel (use_wmark_sel),
    .req_wmark_sel (req_wmark_sel),
    .fifo_depth    (fifo_depth),
    .fifo_full     (fifo_full)
  );

  tlv_trigger u_tlv_trigger (
    .clk            (clk),
    .rst_n          (rst_n),
    .debug_mode     (debug_mode),
    .tlv_rd_d       (tlv_rd_d),
    .tlv_data       (tlv_data),
    .tlv_sop        (tlv_sop),
    .trig_tlv_type  (trig_tlv_type),
    .trig_word_num  (trig_word_num),
    .trig_match_val (trig_match_val),
    .trig_mask_val  (trig_mask_val),
    .freeze_hold    (freeze_hold),
    .trigger_hit    (trigger_hit),
    .trig_cap       (trig_cap)
  );

  debug_gate #(.fifo_entries(fifo_entries)) u_debug_gate (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .debug_mode              (debug_mode),
    .force_ib_bp             (force_ib_bp),
    .fifo_full               (fifo_full),
    .freeze_hold             (freeze_hold),
    .fifo_depth              (fifo_depth),
    .axi_slv_empty           (axi_slv_empty),
    .pre_tlvp_fifo_afull     (pre_tlvp_fifo_afull),
    .pre_tlvp_fifo_empty     (pre_tlvp_fifo_empty),
    .pre_tlvp_fifo_rd        (pre_tlvp_fifo_rd),
    .isf_fifo_hw_wr          (isf_fifo_hw_wr),
    .isf_fifo_hw_rd          (isf_fifo_hw_rd),
    .axi_slv_rd              (axi_slv_rd),
    .pre_tlvp_fifo_empty_mod (pre_tlvp_fifo_empty_mod),
    .pre_tlvp_fifo_wr        (pre_tlvp_fifo_wr),
    .tlv_rd_d                (tlv_rd_d)
  );

endmodule

//--- verilog/debug_gate.sv
// Applies the debug mode to the inbound FIFO strobes. Writes come from the
// AXI slave queue, reads go to the parser FIFO. Strobes are combinational;
// the parser FIFO write and the delayed parser read are registered.
// freeze_hold from the trigger makes the parser see an empty FIFO.
module debug_gate #(
  parameter int fifo_entries = 256,
  localparam int depth_w = $clog2(fifo_entries + 1)
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  isf_dbg_pkg::debug_mode_e debug_mode,
  input  logic                     force_ib_bp,
  input  logic                     fifo_full,
  input  logic                     freeze_hold,
  input  logic [depth_w-1:0]       fifo_depth,
  input  logic                     axi_slv_empty,
  input  logic                     pre_tlvp_fifo_afull,
  input  logic                     pre_tlvp_fifo_empty,
  input  logic                     pre_tlvp_fifo_rd,
  output logic                     isf_fifo_hw_wr,
  output logic                     isf_fifo_hw_rd,
  output logic                     axi_slv_rd,
  output logic                     pre_tlvp_fifo_empty_mod,
  output logic                     pre_tlvp_fifo_wr,
  output logic                     tlv_rd_d
);

  import isf_dbg_pkg::*;

  logic fifo_empty;
  logic rd_ok;
  logic wr_ok;

  assign fifo_empty = fifo_depth == '0;
  assign rd_ok      = !fifo_empty && !pre_tlvp_fifo_afull;
  assign wr_ok      = !axi_slv_empty && !fifo_full;

  always_comb
  begin
    case (debug_mode)
      DBG_NORMAL:
      begin
        isf_fifo_hw_wr = wr_ok && !force_ib_bp;
        isf_fifo_hw_rd = rd_ok;
      end
      DBG_BLK_RDWR:
      begin
        isf_fifo_hw_wr = 1'b0;
        isf_fifo_hw_rd = 1'b0;
      end
      DBG_BLK_RD:
      begin
        isf_fifo_hw_wr = wr_ok;                  // FIFO keeps filling while reads are held
        isf_fifo_hw_rd = 1'b0;
      end
      default:
      begin
        isf_fifo_hw_wr = wr_ok;
        isf_fifo_hw_rd = rd_ok;
      end
    endcase
  end

  assign axi_slv_rd              = isf_fifo_hw_wr;
  assign pre_tlvp_fifo_empty_mod = pre_tlvp_fifo_empty || freeze_hold;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pre_tlvp_fifo_wr <= 1'b0;
      tlv_rd_d         <= 1'b0;
    end
    else
    begin
      pre_tlvp_fifo_wr <= isf_fifo_hw_rd && !pre_tlvp_fifo_afull;
      tlv_rd_d         <= pre_tlvp_fifo_rd;  // Read data shows up one cycle after the strobe
    end
  end

endmodule

//--- verilog/tlv_trigger.sv
// Debug trigger on the parser input. Armed in trigger-freeze mode, it waits
// for the first word of a TLV with the selected type, counts words up to the
// selected index and compares that word with a masked match value. A hit
// freezes the parser through freeze_hold and captures the word in trig_cap.
// tlv_rd_d marks the cycle in which tlv_data and tlv_sop hold a read word.
module tlv_trigger (
  input  logic                     clk,
  input  logic                     rst_n,
  input  isf_dbg_pkg::debug_mode_e debug_mode,
  input  logic                     tlv_rd_d,
  input  isf_dbg_pkg::tlv_data_t   tlv_data,
  input  logic                     tlv_sop,
  input  isf_dbg_pkg::tlv_type_t   trig_tlv_type,
  input  isf_dbg_pkg::word_num_t   trig_word_num,
  input  isf_dbg_pkg::tlv_data_t   trig_match_val,
  input  isf_dbg_pkg::tlv_data_t   trig_mask_val,
  output logic                     freeze_hold,
  output logic                     trigger_hit,
  output isf_dbg_pkg::tlv_data_t   trig_cap
);

  import isf_dbg_pkg::*;

  typedef enum logic [1:0] {
    TF_IDLE,
    TF_CNT,
    TF_HIT
  } tf_state_e;

  tf_state_e tf_st;
  tf_state_e tf_st_nxt;
  word_num_t word_cnt;
  tlv_type_t word_type;
  logic      armed;
  logic      type_match;
  logic      word_num0;
  logic      cnt_match;
  logic      data_match;
  logic      cnt_en;
  logic      cnt_clr;
  logic      cap_ld;
  logic      hit_nxt;

  assign armed      = debug_mode == DBG_TRIG_FREEZE;
  assign word_type  = tlv_data[TLV_TYPE_W-1:0];
  assign type_match = tlv_rd_d && tlv_sop && (word_type == trig_tlv_type);
  assign word_num0  = trig_word_num == '0;
  assign cnt_match  = word_cnt == trig_word_num;

  // Bits outside the mask never block a match
  assign data_match = ((tlv_data ^ trig_match_val) & trig_mask_val) == '0;

  always_comb
  begin
    tf_st_nxt = tf_st;
    cnt_en    = 1'b0;
    cnt_clr   = 1'b0;
    cap_ld    = 1'b0;
    hit_nxt   = 1'b0;
    case (tf_st)
      TF_IDLE:
      begin
        if (armed && type_match && !word_num0)
        begin
          cnt_en    = 1'b1;                      // Type word is word 0, next read is word 1
          tf_st_nxt = TF_CNT;
        end
        else if (armed && type_match && data_match)
        begin
          cap_ld    = 1'b1;
          hit_nxt   = 1'b1;
          tf_st_nxt = TF_HIT;
        end
      end
      TF_CNT:
      begin
        if (!armed)
        begin
          cnt_clr   = 1'b1;
          tf_st_nxt = TF_IDLE;
        end
        else if (tlv_rd_d && cnt_match && data_match)
        begin
          cnt_clr   = 1'b1;
          cap_ld    = 1'b1;
          hit_nxt   = 1'b1;
          tf_st_nxt = TF_HIT;
        end
        else if (tlv_rd_d && cnt_match)
        begin
          cnt_clr   = 1'b1;                      // Wrong value at the chosen word
          tf_st_nxt = TF_IDLE;
        end
        else
        begin
          cnt_en = tlv_rd_d;
        end
      end
      TF_HIT:
      begin
        if (armed)
        begin
          hit_nxt = 1'b1;                        // Parser stays frozen until the mode changes
        end
        else
        begin
          tf_st_nxt = TF_IDLE;
        end
      end
      default:
      begin
        tf_st_nxt = TF_IDLE;
      end
    endcase
  end

  assign freeze_hold = hit_nxt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tf_st       <= TF_IDLE;
      trigger_hit <= 1'b0;
      word_cnt    <= '0;
      trig_cap    <= '0;
    end
    else
    begin
      tf_st       <= tf_st_nxt;
      trigger_hit <= hit_nxt;
      if (cnt_clr)
      begin
        word_cnt <= '0;
      end
      else if (cnt_en)
      begin
        word_cnt <= word_cnt + word_num_t'(1);
      end
      if (cap_ld)
      begin
        trig_cap <= tlv_data;
      end
    end
  end

endmodule

//--- verilog/watermark_flow.sv
// Inbound FIFO back-pressure with hysteresis. Back-pressure is raised when
// the depth reaches fifo_entries minus the use watermark, and released once
// the depth has fallen to fifo_entries minus (use + request) watermarks.
// fifo_full is a flop output and lags the depth compare by one cycle.
module watermark_flow #(
  parameter int fifo_entries = 256,
  localparam int depth_w = $clog2(fifo_entries + 1)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  isf_dbg_pkg::wmark_sel_t use_wmark_sel,
  input  isf_dbg_pkg::wmark_sel_t req_wmark_sel,
  input  logic [depth_w-1:0]      fifo_depth,
  output logic                    fifo_full
);

  import isf_dbg_pkg::*;

  typedef enum logic {
    FULL_IDLE,
    FULL_BP
  } full_state_e;

  full_state_e        full_st;
  logic [depth_w-1:0] use_wmark;
  logic [depth_w-1:0] req_wmark;
  logic [depth_w-1:0] high_thr;
  logic [depth_w-1:0] low_thr;
  logic               high_hit;
  logic               low_hit;

  // Number of entries that a select code stands for
  function automatic logic [depth_w-1:0] wmark_entries(input wmark_sel_t sel);
    return depth_w'((int'(sel) + 1) * WMARK_STEP);
  endfunction

  assign use_wmark = wmark_entries(use_wmark_sel);
  assign req_wmark = wmark_entries(req_wmark_sel);

  // fifo_entries is above 128, so neither threshold can wrap
  assign high_thr = depth_w'(fifo_entries) - use_wmark;
  assign low_thr  = depth_w'(fifo_entries) - (use_wmark + req_wmark);

  assign high_hit = fifo_depth >= high_thr;
  assign low_hit  = fifo_depth <= low_thr;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full_st <= FULL_IDLE;
    end
    else
    begin
      case (full_st)
        FULL_IDLE:
        begin
          if (high_hit)
          begin
            full_st <= FULL_BP;
          end
        end
        FULL_BP:
        begin
          if (low_hit)
          begin
            full_st <= FULL_IDLE;                // Drained far enough to take writes again
          end
        end
        default:
        begin
          full_st <= FULL_IDLE;
        end
      endcase
    end
  end

  assign fifo_full = full_st == FULL_BP;

endmodule

//--- verilog/isf_dbg_pkg.sv
// Shared widths, vector types and the debug-mode encoding for the inbound
// debug and flow controller. Modules take these through a wildcard import
// in the body, and name them with the package prefix in their port lists.
package isf_dbg_pkg;

  // TLV data path
  parameter int DATA_W     = 64;
  parameter int TLV_TYPE_W = 8;                  // Type lives in bits 7:0 of word 0
  parameter int WORD_NUM_W = 21;

  // Watermark select codes
  parameter int WMARK_SEL_W = 3;
  parameter int WMARK_STEP  = 8;                 // Each select step adds this many entries

  // A data word, a match value, a mask or a captured word
  typedef logic [DATA_W-1:0] tlv_data_t;

  // Type field of the first TLV word
  typedef logic [TLV_TYPE_W-1:0] tlv_type_t;

  // Word index inside a TLV and the running word counter
  typedef logic [WORD_NUM_W-1:0] word_num_t;

  // Code s selects (s+1)*WMARK_STEP entries
  typedef logic [WMARK_SEL_W-1:0] wmark_sel_t;

  // Debug modes; code 3 used to be single step and now acts as normal
  typedef enum logic [2:0] {
    DBG_NORMAL      = 3'd0,
    DBG_BLK_RDWR    = 3'd1,
    DBG_BLK_RD      = 3'd2,
    DBG_RESERVED_SS = 3'd3,
    DBG_TRIG_FREEZE = 3'd4
  } debug_mode_e;

endpackage
